// File: design/vram_regs_pkg.sv
// ==========================================================
// host register map definitions
// ==========================================================

package vram_regs_pkg;

    // bus and memory word types
    typedef logic [15:0] word_t;        // register or vram data word
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  byte_t;        // one host bus byte
    typedef logic [3:0]  reg_num_t;     // host register number
    typedef logic [3:0]  wrmask_t;      // per nibble write enable

    // host register numbers
    localparam reg_num_t XM_SYS_CTRL = 4'h0;    // mem-wait flag and write mask
    localparam reg_num_t XM_TIMER    = 4'h2;    // 1/10 ms timer
    localparam reg_num_t XM_RD_INCR  = 4'h6;    // read address step
    localparam reg_num_t XM_RD_ADDR  = 4'h7;    // read address, odd byte starts pre-read
    localparam reg_num_t XM_WR_INCR  = 4'h8;    // write address step
    localparam reg_num_t XM_WR_ADDR  = 4'h9;    // write address
    localparam reg_num_t XM_DATA     = 4'hA;    // vram data port
    localparam reg_num_t XM_DATA_2   = 4'hB;    // second alias of data port

    // timer rate as reduced fraction clk_hz / tick_hz
    // sim values give one tick per 50 clocks
    localparam int TICK_CLK_REDUCED = 50;       // reduced clock rate
    localparam int TICK_HZ_REDUCED  = 1;        // reduced tick rate

    // one extra bit so the accumulator can go negative
    localparam int TICK_FRAC_BITS = $clog2(TICK_CLK_REDUCED) + 1;

    // signed tick accumulator word
    typedef logic signed [TICK_FRAC_BITS-1:0] tick_frac_t;

    // write mask after reset, every nibble writable
    localparam wrmask_t WRMASK_RESET = 4'b1111;

endpackage

// File: design/vram_req_if.sv
// ==========================================================
// vram request channel
// ==========================================================
`default_nettype none
`timescale 1ns/1ps

interface vram_req_if;

    logic                   rd_req;     // read start pulse
    logic                   wr_req;     // write start pulse
    vram_regs_pkg::addr_t   addr;       // access address
    vram_regs_pkg::word_t   wdata;      // write data
    vram_regs_pkg::wrmask_t wrmask;     // nibble write mask
    logic                   busy;       // access pending
    logic                   rd_done;    // read finished pulse
    logic                   wr_done;    // write finished pulse
    vram_regs_pkg::word_t   rdata;      // captured read word

    // register file side, issues requests
    modport regs (
        output rd_req, wr_req, addr, wdata, wrmask,
        input  busy, rd_done, wr_done, rdata
    );

    // sequencer side, serves requests
    modport seq (
        input  rd_req, wr_req, addr, wdata, wrmask,
        output busy, rd_done, wr_done, rdata
    );

endinterface

`default_nettype wire

// File: design/tenth_ms_timer.sv
// ==========================================================
// 1/10 ms timer
// ==========================================================
`default_nettype none
`timescale 1ns/1ps

module tenth_ms_timer (
    input  wire logic           clk,            // system clock
    input  wire logic           reset_i,        // sync reset
    output vram_regs_pkg::word_t timer_o        // free running tick count
);

    // accumulator steps hz each clock, pays back clk on a tick
    // so an uneven clock/tick ratio still averages out exactly
    vram_regs_pkg::tick_frac_t  frac_q;         // fractional phase
    vram_regs_pkg::tick_frac_t  step_idle;      // step without tick
    vram_regs_pkg::tick_frac_t  step_tick;      // step with tick
    logic                       tick;           // phase crossed zero

    assign step_idle = vram_regs_pkg::tick_frac_t'(vram_regs_pkg::TICK_HZ_REDUCED);
    assign step_tick = vram_regs_pkg::tick_frac_t'(vram_regs_pkg::TICK_HZ_REDUCED
                                                 - vram_regs_pkg::TICK_CLK_REDUCED);

    // non-negative phase means a tick is due
    assign tick = ~frac_q[vram_regs_pkg::TICK_FRAC_BITS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac_q  <= '0;
            timer_o <= '0;
        end else begin
            if (tick) begin
                frac_q  <= frac_q + step_tick;      // pay back one period
                timer_o <= timer_o + 16'd1;         // count 1/10 ms
            end else begin
                frac_q  <= frac_q + step_idle;      // creep toward zero
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vram_access_fsm.sv
// ==========================================================
// vram access sequencer
// ==========================================================
`default_nettype none
`timescale 1ns/1ps

module vram_access_fsm (
    input  wire logic               clk,            // system clock
    input  wire logic               reset_i,        // sync reset
    vram_req_if.seq                 req,            // request channel from regs
    input  wire logic               vram_ack_i,     // vram access done
    input  wire vram_regs_pkg::word_t vram_data_i,  // read data, valid with ack
    output logic                    vram_sel_o,     // vram select, held until ack
    output logic                    vram_wr_o,      // write when high
    output vram_regs_pkg::wrmask_t  vram_wrmask_o,  // nibble write mask
    output vram_regs_pkg::addr_t    vram_addr_o,    // access address
    output vram_regs_pkg::word_t    vram_data_o     // write data
);

    // state lives in the two select flops
    //   idle          sel=0
    //   read pending  sel=1 wr=0
    //   write pending sel=1 wr=1
    logic   ack_taken;                              // pending access acknowledged
    logic   new_req;                                // any request this cycle

    assign ack_taken = vram_sel_o & vram_ack_i;
    assign new_req   = req.rd_req | req.wr_req;
    assign req.busy  = vram_sel_o;                  // pending until ack edge

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
            req.rd_done <= 1'b0;
            req.wr_done <= 1'b0;
        end else begin
            req.rd_done <= ack_taken & ~vram_wr_o;  // one cycle after ack
            req.wr_done <= ack_taken & vram_wr_o;
            if (ack_taken) begin
                vram_sel_o <= 1'b0;                 // back to idle
                vram_wr_o  <= 1'b0;
            end
            // a request, even while busy, replaces what is pending
            if (req.wr_req) begin
                vram_sel_o <= 1'b1;                 // write pending
                vram_wr_o  <= 1'b1;
            end else if (req.rd_req) begin
                vram_sel_o <= 1'b1;                 // read pending
                vram_wr_o  <= 1'b0;
            end
        end
    end

    // payload, captured with the request and frozen until ack
    always_ff @(posedge clk) begin
        if (new_req) begin
            vram_addr_o   <= req.addr;
            vram_data_o   <= req.wdata;
            vram_wrmask_o <= req.wrmask;
        end
        if (ack_taken && !vram_wr_o) begin
            req.rdata <= vram_data_i;               // read word at ack
        end
    end

endmodule

`default_nettype wire

// File: design/xm_reg_file.sv
// ==========================================================
// host register file
// ==========================================================
`default_nettype none
`timescale 1ns/1ps

module xm_reg_file (
    input  wire logic                   clk,                // system clock
    input  wire logic                   reset_i,            // sync reset
    input  wire logic                   bus_write_strobe_i, // byte write, one cycle
    input  wire logic                   bus_read_strobe_i,  // byte read, one cycle
    input  wire vram_regs_pkg::reg_num_t bus_reg_num_i,     // register number
    input  wire logic                   bus_bytesel_i,      // 0 even byte, 1 odd byte
    input  wire vram_regs_pkg::byte_t   bus_data_i,         // write byte
    input  wire vram_regs_pkg::word_t   timer_i,            // live timer word
    vram_req_if.regs                    req,                // vram request channel
    output vram_regs_pkg::byte_t        bus_data_o          // read byte
);

    vram_regs_pkg::byte_t   hold_q;         // even byte for control regs
    vram_regs_pkg::byte_t   data_even_q;    // even byte for DATA port
    vram_regs_pkg::word_t   rd_incr_q;      // RD_INCR
    vram_regs_pkg::addr_t   rd_addr_q;      // RD_ADDR
    vram_regs_pkg::word_t   wr_incr_q;      // WR_INCR
    vram_regs_pkg::addr_t   wr_addr_q;      // WR_ADDR
    vram_regs_pkg::wrmask_t wrmask_q;       // nibble write mask
    vram_regs_pkg::word_t   data_q;         // last pre-read word
    vram_regs_pkg::byte_t   timer_lo_q;     // timer low byte, latched
    logic                   rd_incr_flag;   // step RD_ADDR next edge
    logic                   wr_incr_flag;   // step WR_ADDR next edge

    vram_regs_pkg::word_t   bus_word;       // held even byte + odd byte
    vram_regs_pkg::word_t   rd_word;        // selected register for read
    logic                   is_data;        // DATA or DATA_2 addressed
    logic                   rd_addr_wr;     // odd write to RD_ADDR
    logic                   data_wr;        // odd write to DATA
    logic                   data_rd;        // odd read of DATA

    assign bus_word   = {hold_q, bus_data_i};
    assign is_data    = (bus_reg_num_i == vram_regs_pkg::XM_DATA) ||
                        (bus_reg_num_i == vram_regs_pkg::XM_DATA_2);
    assign rd_addr_wr = bus_write_strobe_i & bus_bytesel_i &
                        (bus_reg_num_i == vram_regs_pkg::XM_RD_ADDR);
    assign data_wr    = bus_write_strobe_i & bus_bytesel_i & is_data;
    assign data_rd    = bus_read_strobe_i & bus_bytesel_i & is_data;

    // requests leave in the strobe cycle, sequencer registers them
    assign req.rd_req = rd_addr_wr | data_rd;       // pre-read
    assign req.wr_req = data_wr;
    assign req.wdata  = {data_even_q, bus_data_i};
    assign req.wrmask = wrmask_q;

    always_comb begin
        if (data_wr) begin
            req.addr = wr_addr_q;
        end else if (rd_addr_wr) begin
            req.addr = bus_word;                    // new RD_ADDR value
        end else begin
            req.addr = rd_addr_q;                   // next stream word
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_q       <= '0;
            data_even_q  <= '0;
            rd_incr_q    <= '0;
            rd_addr_q    <= '0;
            wr_incr_q    <= '0;
            wr_addr_q    <= '0;
            wrmask_q     <= vram_regs_pkg::WRMASK_RESET;
            data_q       <= '0;
            timer_lo_q   <= '0;
            rd_incr_flag <= 1'b0;
            wr_incr_flag <= 1'b0;
        end else begin
            rd_incr_flag <= req.rd_done;
            wr_incr_flag <= req.wr_done;
            if (req.rd_done) begin
                data_q <= req.rdata;                // keep for next DATA read
            end
            if (rd_incr_flag) begin
                rd_addr_q <= rd_addr_q + rd_incr_q;
            end
            if (wr_incr_flag) begin
                wr_addr_q <= wr_addr_q + wr_incr_q;
            end
            // host writes come last so they win over an auto step
            if (bus_write_strobe_i && !bus_bytesel_i) begin
                if (is_data) begin
                    data_even_q <= bus_data_i;
                end else begin
                    hold_q <= bus_data_i;
                end
            end
            if (bus_write_strobe_i && bus_bytesel_i) begin
                case (bus_reg_num_i)
                    vram_regs_pkg::XM_SYS_CTRL: wrmask_q  <= bus_data_i[3:0];
                    vram_regs_pkg::XM_RD_INCR:  rd_incr_q <= bus_word;
                    vram_regs_pkg::XM_RD_ADDR:  rd_addr_q <= bus_word;
                    vram_regs_pkg::XM_WR_INCR:  wr_incr_q <= bus_word;
                    vram_regs_pkg::XM_WR_ADDR:  wr_addr_q <= bus_word;
                    default: begin
                    end
                endcase
            end
            if (bus_read_strobe_i && !bus_bytesel_i) begin
                timer_lo_q <= timer_i[7:0];         // coherent word for odd read
            end
        end
    end

    always_comb begin
        case (bus_reg_num_i)
            vram_regs_pkg::XM_SYS_CTRL: rd_word = {req.busy, 11'b0, wrmask_q};
            vram_regs_pkg::XM_TIMER:    rd_word = {timer_i[15:8], timer_lo_q};
            vram_regs_pkg::XM_RD_INCR:  rd_word = rd_incr_q;
            vram_regs_pkg::XM_RD_ADDR:  rd_word = rd_addr_q;
            vram_regs_pkg::XM_WR_INCR:  rd_word = wr_incr_q;
            vram_regs_pkg::XM_WR_ADDR:  rd_word = wr_addr_q;
            vram_regs_pkg::XM_DATA,
            vram_regs_pkg::XM_DATA_2:   rd_word = data_q;
            default:                    rd_word = '0;   // unused numbers
        endcase
    end

    // even byte is the high half
    assign bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

`default_nettype wire

// File: design/xm_reg_interface.sv
// ==========================================================
// host register interface top
// ==========================================================
`default_nettype none
`timescale 1ns/1ps

module xm_reg_interface (
    input  wire logic                   clk,                // system clock
    input  wire logic                   reset_i,            // sync reset
    // host bus, already synchronized
    input  wire logic                   bus_write_strobe_i, // byte write strobe
    input  wire logic                   bus_read_strobe_i,  // byte read strobe
    input  wire vram_regs_pkg::reg_num_t bus_reg_num_i,     // register number
    input  wire logic                   bus_bytesel_i,      // 0 even, 1 odd
    input  wire vram_regs_pkg::byte_t   bus_data_i,         // write byte
    output vram_regs_pkg::byte_t        bus_data_o,         // read byte, same cycle
    // vram port
    input  wire logic                   vram_ack_i,         // access done
    input  wire vram_regs_pkg::word_t   vram_data_i,        // read data at ack
    output logic                        vram_sel_o,         // select until ack
    output logic                        vram_wr_o,          // write access
    output vram_regs_pkg::wrmask_t      vram_wrmask_o,      // nibble mask
    output vram_regs_pkg::addr_t        vram_addr_o,        // word address
    output vram_regs_pkg::word_t        vram_data_o         // write data
);

    vram_regs_pkg::word_t   timer;      // 1/10 ms count

    vram_req_if req ();                 // regs to sequencer

    tenth_ms_timer u_tenth_ms_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

    xm_reg_file u_xm_reg_file (
        .clk                (clk),
        .reset_i            (reset_i),
        .bus_write_strobe_i (bus_write_strobe_i),
        .bus_read_strobe_i  (bus_read_strobe_i),
        .bus_reg_num_i      (bus_reg_num_i),
        .bus_bytesel_i      (bus_bytesel_i),
        .bus_data_i         (bus_data_i),
        .timer_i            (timer),
        .req                (req.regs),
        .bus_data_o         (bus_data_o)
    );

    vram_access_fsm u_vram_access_fsm (
        .clk           (clk),
        .reset_i       (reset_i),
        .req           (req.seq),
        .vram_ack_i    (vram_ack_i),
        .vram_data_i   (vram_data_i),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_wrmask_o (vram_wrmask_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o)
    );

endmodule

`default_nettype wire

// File: test/xm_reg_interface_assert.sv
// ==========================================================
// vram handshake assertions
// ==========================================================
`timescale 1ns/1ps

module xm_reg_interface_assert (
    input logic                   clk,          // system clock
    input logic                   reset_i,      // sync reset
    input logic                   sel_i,        // vram select
    input logic                   wr_i,         // write access
    input logic                   ack_i,        // vram acknowledge
    input vram_regs_pkg::addr_t   addr_i,       // access address
    input vram_regs_pkg::word_t   data_i,       // write data
    input vram_regs_pkg::wrmask_t wrmask_i,     // nibble mask
    input logic                   rd_done_i,    // read finished pulse
    input logic                   wr_done_i     // write finished pulse
);

    // request stays presented until the vram takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
        (sel_i && !ack_i) |=> (sel_i && $stable(addr_i) && $stable(data_i)
                               && $stable(wr_i) && $stable(wrmask_i)))
        else $error("vram request changed or dropped before acknowledge");

    a_sel_falls: assert property (@(posedge clk) disable iff (reset_i)
        (sel_i && ack_i) |=> !sel_i)
        else $error("vram select still high after acknowledge");

    a_done_onehot: assert property (@(posedge clk) disable iff (reset_i)
        !(rd_done_i && wr_done_i))
        else $error("read and write done pulses high together");

endmodule

bind vram_access_fsm xm_reg_interface_assert u_xm_reg_interface_assert (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (vram_sel_o),
    .wr_i      (vram_wr_o),
    .ack_i     (vram_ack_i),
    .addr_i    (vram_addr_o),
    .data_i    (vram_data_o),
    .wrmask_i  (vram_wrmask_o),
    .rd_done_i (req.rd_done),
    .wr_done_i (req.wr_done)
);

// File: test/xm_reg_interface_tb.sv
// ============================================================
// host register interface testbench
// ============================================================
`timescale 1ns/1ps

module xm_reg_interface_tb;

    localparam int CLK_PERIOD   = 20;           // ns
    localparam int RESET_CYCLES = 5;
    localparam int LAT_MIN      = 1;            // vram ack latency range, cycles
    localparam int LAT_MAX      = 4;

    // row operations
    localparam int OP_REG_WR  = 0;              // register write
    localparam int OP_REG_RD  = 1;              // register read, literal expected
    localparam int OP_ADDR_RD = 2;              // address read, scoreboard expected
    localparam int OP_DATA_WR = 3;              // DATA write
    localparam int OP_DATA_RD = 4;              // DATA read, scoreboard expected
    localparam int OP_MEM_CHK = 5;              // model word against scoreboard
    localparam int OP_POLL    = 6;              // wait for mem-wait low
    localparam int OP_TIMER   = 7;              // two timer reads, word = idle cycles

    logic                       clk;
    logic                       reset_i;
    logic                       bus_write_strobe_i;
    logic                       bus_read_strobe_i;
    vram_regs_pkg::reg_num_t    bus_reg_num_i;
    logic                       bus_bytesel_i;
    vram_regs_pkg::byte_t       bus_data_i;
    vram_regs_pkg::byte_t       bus_data_o;
    logic                       vram_ack_i;
    vram_regs_pkg::word_t       vram_data_i;
    logic                       vram_sel_o;
    logic                       vram_wr_o;
    vram_regs_pkg::wrmask_t     vram_wrmask_o;
    vram_regs_pkg::addr_t       vram_addr_o;
    vram_regs_pkg::word_t       vram_data_o;

    integer                     seed = 82;      // latency draws
    int                         lat_left = -1;  // cycles to ack, -1 idle
    int                         errors = 0;
    int                         checks = 0;
    logic                       table_ready = 1'b0;

    // stimulus table columns
    string                      row_name[$];
    int                         row_op[$];
    vram_regs_pkg::reg_num_t    row_num[$];
    vram_regs_pkg::word_t       row_word[$];
    vram_regs_pkg::word_t       row_exp[$];

    vram_regs_pkg::word_t       vram_mem [0:65535];     // vram model
    vram_regs_pkg::word_t       exp_mem [0:65535];      // scoreboard image
    vram_regs_pkg::addr_t       sb_rd_addr;
    vram_regs_pkg::addr_t       sb_wr_addr;
    vram_regs_pkg::word_t       sb_rd_incr;
    vram_regs_pkg::word_t       sb_wr_incr;
    vram_regs_pkg::word_t       sb_data;                // word the next DATA read returns
    vram_regs_pkg::wrmask_t     sb_mask;

    xm_reg_interface u_xm_reg_interface (
        .clk                (clk),
        .reset_i            (reset_i),
        .bus_write_strobe_i (bus_write_strobe_i),
        .bus_read_strobe_i  (bus_read_strobe_i),
        .bus_reg_num_i      (bus_reg_num_i),
        .bus_bytesel_i      (bus_bytesel_i),
        .bus_data_i         (bus_data_i),
        .bus_data_o         (bus_data_o),
        .vram_ack_i         (vram_ack_i),
        .vram_data_i        (vram_data_i),
        .vram_sel_o         (vram_sel_o),
        .vram_wr_o          (vram_wr_o),
        .vram_wrmask_o      (vram_wrmask_o),
        .vram_addr_o        (vram_addr_o),
        .vram_data_o        (vram_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // odd multiplier keeps every address distinct
    function automatic vram_regs_pkg::word_t fill_word(input int addr);
        return 16'(addr * 40503) ^ 16'h5AA5;
    endfunction

    function automatic vram_regs_pkg::word_t apply_mask(input vram_regs_pkg::word_t old_word,
                                                        input vram_regs_pkg::word_t new_word,
                                                        input vram_regs_pkg::wrmask_t mask);
        vram_regs_pkg::word_t merged;
        merged = old_word;
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                merged[4*k +: 4] = new_word[4*k +: 4];  // enabled nibble only
            end
        end
        return merged;
    endfunction

    // vram model, ack after a random 1..4 cycles
    always @(negedge clk) begin
        vram_ack_i = 1'b0;
        if (!vram_sel_o) begin
            lat_left = -1;
        end else begin
            if (lat_left < 0) begin
                lat_left = LAT_MIN + int'($unsigned($random(seed)) % (LAT_MAX - LAT_MIN + 1));
            end
            lat_left = lat_left - 1;
            if (lat_left == 0) begin
                vram_ack_i = 1'b1;
                lat_left   = -1;
                if (vram_wr_o) begin
                    vram_mem[vram_addr_o] = apply_mask(vram_mem[vram_addr_o], vram_data_o,
                                                       vram_wrmask_o);
                end else begin
                    vram_data_i = vram_mem[vram_addr_o];    // valid in ack cycle
                end
            end
        end
    end

    task automatic check_word(input string name, input vram_regs_pkg::word_t expected,
                              input vram_regs_pkg::word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: expected %04h, actual %04h", name, expected, actual);
        end
    endtask

    // even byte first, odd byte completes the word
    task automatic write_word(input vram_regs_pkg::reg_num_t num,
                              input vram_regs_pkg::word_t word);
        bus_reg_num_i      = num;
        bus_bytesel_i      = 1'b0;
        bus_data_i         = word[15:8];
        bus_write_strobe_i = 1'b1;
        @(negedge clk);
        bus_bytesel_i      = 1'b1;
        bus_data_i         = word[7:0];
        @(negedge clk);
        bus_write_strobe_i = 1'b0;
    endtask

    task automatic read_byte(input vram_regs_pkg::reg_num_t num, input logic odd,
                             output vram_regs_pkg::byte_t rd_byte);
        bus_reg_num_i     = num;
        bus_bytesel_i     = odd;
        bus_read_strobe_i = 1'b1;
        #(CLK_PERIOD/4);                            // mux settled, well before the edge
        rd_byte = bus_data_o;
        @(negedge clk);
        bus_read_strobe_i = 1'b0;
    endtask

    task automatic read_word(input vram_regs_pkg::reg_num_t num,
                             output vram_regs_pkg::word_t word);
        vram_regs_pkg::byte_t hi;
        vram_regs_pkg::byte_t lo;
        read_byte(num, 1'b0, hi);
        read_byte(num, 1'b1, lo);
        word = {hi, lo};
    endtask

    task automatic wait_idle();
        vram_regs_pkg::byte_t status;
        do begin
            read_byte(vram_regs_pkg::XM_SYS_CTRL, 1'b0, status);
        end while (status[7]);                      // mem-wait, bit 15
        repeat (2) @(negedge clk);                  // done flag and address step
    endtask

    task automatic add_row(input string name, input int op, input vram_regs_pkg::reg_num_t num,
                           input vram_regs_pkg::word_t word, input vram_regs_pkg::word_t exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_num.push_back(num);
        row_word.push_back(word);
        row_exp.push_back(exp);
    endtask

    task automatic build_table();
        add_row("reset sys_ctrl", OP_REG_RD, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h000F);
        add_row("reset rd_incr", OP_REG_RD, vram_regs_pkg::XM_RD_INCR, 16'h0000, 16'h0000);
        add_row("reset rd_addr", OP_REG_RD, vram_regs_pkg::XM_RD_ADDR, 16'h0000, 16'h0000);
        add_row("reset wr_incr", OP_REG_RD, vram_regs_pkg::XM_WR_INCR, 16'h0000, 16'h0000);
        add_row("reset wr_addr", OP_REG_RD, vram_regs_pkg::XM_WR_ADDR, 16'h0000, 16'h0000);
        add_row("reset data", OP_DATA_RD, vram_regs_pkg::XM_DATA, 16'h0000, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("set rd_incr", OP_REG_WR, vram_regs_pkg::XM_RD_INCR, 16'h1234, 16'h0000);
        add_row("readback rd_incr", OP_REG_RD, vram_regs_pkg::XM_RD_INCR, 16'h0000, 16'h1234);
        add_row("set wr_incr", OP_REG_WR, vram_regs_pkg::XM_WR_INCR, 16'h0003, 16'h0000);
        add_row("readback wr_incr", OP_REG_RD, vram_regs_pkg::XM_WR_INCR, 16'h0000, 16'h0003);
        add_row("set wr_addr", OP_REG_WR, vram_regs_pkg::XM_WR_ADDR, 16'h0100, 16'h0000);
        add_row("readback wr_addr", OP_REG_RD, vram_regs_pkg::XM_WR_ADDR, 16'h0000, 16'h0100);
        add_row("set mask", OP_REG_WR, vram_regs_pkg::XM_SYS_CTRL, 16'h0005, 16'h0000);
        add_row("readback mask", OP_REG_RD, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0005);
        add_row("masked write", OP_DATA_WR, vram_regs_pkg::XM_DATA, 16'hABCD, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("masked word", OP_MEM_CHK, vram_regs_pkg::XM_DATA, 16'h0100, 16'h0000);
        add_row("full mask", OP_REG_WR, vram_regs_pkg::XM_SYS_CTRL, 16'h000F, 16'h0000);
        add_row("stream base", OP_REG_WR, vram_regs_pkg::XM_WR_ADDR, 16'h0200, 16'h0000);
        add_row("write 0", OP_DATA_WR, vram_regs_pkg::XM_DATA, 16'hBEEF, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("write 1", OP_DATA_WR, vram_regs_pkg::XM_DATA, 16'h1357, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("write 2", OP_DATA_WR, vram_regs_pkg::XM_DATA_2, 16'hCAFE, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("vram word 0", OP_MEM_CHK, vram_regs_pkg::XM_DATA, 16'h0200, 16'h0000);
        add_row("vram word 1", OP_MEM_CHK, vram_regs_pkg::XM_DATA, 16'h0203, 16'h0000);
        add_row("vram word 2", OP_MEM_CHK, vram_regs_pkg::XM_DATA, 16'h0206, 16'h0000);
        add_row("wr_addr stepped", OP_ADDR_RD, vram_regs_pkg::XM_WR_ADDR, 16'h0000, 16'h0000);
        add_row("read step", OP_REG_WR, vram_regs_pkg::XM_RD_INCR, 16'h0003, 16'h0000);
        add_row("read base", OP_REG_WR, vram_regs_pkg::XM_RD_ADDR, 16'h01FD, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("stream 0", OP_DATA_RD, vram_regs_pkg::XM_DATA, 16'h0000, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("stream 1", OP_DATA_RD, vram_regs_pkg::XM_DATA, 16'h0000, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("stream 2", OP_DATA_RD, vram_regs_pkg::XM_DATA_2, 16'h0000, 16'h0000);
        add_row("poll", OP_POLL, vram_regs_pkg::XM_SYS_CTRL, 16'h0000, 16'h0000);
        add_row("rd_addr stepped", OP_ADDR_RD, vram_regs_pkg::XM_RD_ADDR, 16'h0000, 16'h0000);
        add_row("timer", OP_TIMER, vram_regs_pkg::XM_TIMER, 16'd200, 16'h0000);
    endtask

    task automatic run_row(input int i);
        vram_regs_pkg::word_t rd;
        vram_regs_pkg::word_t t0;
        int ticks;
        int want;
        case (row_op[i])
            OP_REG_WR: begin
                write_word(row_num[i], row_word[i]);
                case (row_num[i])
                    vram_regs_pkg::XM_SYS_CTRL: sb_mask    = row_word[i][3:0];
                    vram_regs_pkg::XM_RD_INCR:  sb_rd_incr = row_word[i];
                    vram_regs_pkg::XM_WR_INCR:  sb_wr_incr = row_word[i];
                    vram_regs_pkg::XM_WR_ADDR:  sb_wr_addr = row_word[i];
                    vram_regs_pkg::XM_RD_ADDR: begin
                        sb_data    = exp_mem[row_word[i]];      // pre-read on odd byte
                        sb_rd_addr = row_word[i] + sb_rd_incr;
                    end
                    default: begin
                    end
                endcase
            end
            OP_REG_RD: begin
                read_word(row_num[i], rd);
                check_word(row_name[i], row_exp[i], rd);
            end
            OP_ADDR_RD: begin
                read_word(row_num[i], rd);
                check_word(row_name[i],
                           (row_num[i] == vram_regs_pkg::XM_RD_ADDR) ? sb_rd_addr : sb_wr_addr,
                           rd);
            end
            OP_DATA_WR: begin
                write_word(row_num[i], row_word[i]);
                exp_mem[sb_wr_addr] = apply_mask(exp_mem[sb_wr_addr], row_word[i], sb_mask);
                sb_wr_addr = sb_wr_addr + sb_wr_incr;
            end
            OP_DATA_RD: begin
                read_word(row_num[i], rd);
                check_word(row_name[i], sb_data, rd);
                sb_data    = exp_mem[sb_rd_addr];       // odd read fetched the next word
                sb_rd_addr = sb_rd_addr + sb_rd_incr;
            end
            OP_MEM_CHK: check_word(row_name[i], exp_mem[row_word[i]], vram_mem[row_word[i]]);
            OP_POLL:    wait_idle();
            OP_TIMER: begin
                read_word(vram_regs_pkg::XM_TIMER, t0);
                repeat (int'(row_word[i])) @(negedge clk);
                read_word(vram_regs_pkg::XM_TIMER, rd);
                want  = int'(row_word[i]) * vram_regs_pkg::TICK_HZ_REDUCED
                        / vram_regs_pkg::TICK_CLK_REDUCED;
                ticks = int'(rd) - int'(t0);
                checks++;
                assert (ticks >= 0 && ticks >= want - 1 && ticks <= want + 1) else begin
                    errors++;
                    $display("FAILED %s: expected %0d ticks, actual %0d", row_name[i], want,
                             ticks);
                end
            end
            default: begin
                errors++;
                $display("Row %0d has an unknown operation and was not run", i);
            end
        endcase
    endtask

    initial begin
        int a;
        int i;
        bus_write_strobe_i = 1'b0;
        bus_read_strobe_i  = 1'b0;
        bus_reg_num_i      = '0;
        bus_bytesel_i      = 1'b0;
        bus_data_i         = '0;
        vram_ack_i         = 1'b0;
        vram_data_i        = '0;
        reset_i            = 1'b1;
        for (a = 0; a < 65536; a++) begin
            vram_mem[a] = fill_word(a);
            exp_mem[a]  = fill_word(a);
        end
        sb_rd_addr = '0;
        sb_wr_addr = '0;
        sb_rd_incr = '0;
        sb_wr_incr = '0;
        sb_data    = '0;
        sb_mask    = vram_regs_pkg::WRMASK_RESET;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        for (i = 0; i < row_op.size(); i++) begin
            run_row(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, budget scales with table length
    initial begin
        int limit;
        wait (table_ready);
        limit = row_op.size() * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

// File: tb.f
design/vram_regs_pkg.sv
design/vram_req_if.sv
design/tenth_ms_timer.sv
design/vram_access_fsm.sv
design/xm_reg_file.sv
design/xm_reg_interface.sv
test/xm_reg_interface_assert.sv
test/xm_reg_interface_tb.sv

// File: Makefile
# Verilator build and run of the host register interface testbench

TOP := xm_reg_interface_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
